/* common/exu_pkg.sv */
package exu_pkg;

    localparam int xlen        = 32;
    localparam int queue_depth = 4;   // also the decoder's starting credit count
    localparam int credit_w    = 3;   // holds 0..queue_depth
    localparam int qptr_w      = 2;   // issue queue pointer width
    localparam int mem_words   = 256;
    localparam int mem_aw      = 8;   // word address into data memory

    // major opcodes of the supported subset
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [31:0] ebreak_instr = 32'h0010_0073; // the only system op we accept

    // operand pair for the alu, written as {a, b}
    typedef enum logic [1:0] {
        src_imm_zero = 2'b00,   // {0, imm}
        src_pc_imm   = 2'b01,   // {pc, imm}
        src_rs1_rs2  = 2'b10,   // {rs1, rs2}
        src_rs1_imm  = 2'b11    // {rs1, imm}
    } src_sel_e;

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_slt    = 3'd5,   // signed compare
        alu_pass_b = 3'd6    // lui
    } alu_op_e;

    // which pair feeds the next-pc adder
    typedef enum logic [1:0] {
        npc_pc_plus4 = 2'b00,
        npc_pc_imm   = 2'b01,   // jal
        npc_rs1_imm  = 2'b10    // jalr
    } npc_sel_e;

    // store size, masks 0 / 1 / 3 / f before the byte-offset shift
    typedef enum logic [1:0] {
        mem_none = 2'b00,
        mem_byte = 2'b01,
        mem_half = 2'b10,
        mem_word = 2'b11
    } mem_size_e;

    typedef struct packed {
        src_sel_e        src_sel;
        alu_op_e         alu_op;
        npc_sel_e        npc_sel;
        mem_size_e       mem_size;
        logic            is_load;
        logic            is_link;    // jal / jalr, rd gets pc+4
        logic            is_ebreak;
        logic            illegal;
        logic [xlen-1:0] imm;        // already sign extended
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1_d;
        logic [xlen-1:0] rs2_d;
    } issue_pkt_t;

endpackage

/* execute/alu.sv */
`timescale 1ns/100ps

module alu (
    input  logic [exu_pkg::xlen-1:0] a,
    input  logic [exu_pkg::xlen-1:0] b,
    input  exu_pkg::alu_op_e         op,
    output logic [exu_pkg::xlen-1:0] res
);

    logic lt;   // signed less-than

    assign lt = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            exu_pkg::alu_add:    res = a + b;
            exu_pkg::alu_sub:    res = a - b;
            exu_pkg::alu_and:    res = a & b;
            exu_pkg::alu_or:     res = a | b;
            exu_pkg::alu_xor:    res = a ^ b;
            exu_pkg::alu_slt:    res = {{(exu_pkg::xlen-1){1'b0}}, lt};
            exu_pkg::alu_pass_b: res = b;   // lui puts the u-immediate on b
            default:             res = a + b;
        endcase
    end

endmodule

/* decode/op_decoder.sv */
`timescale 1ns/100ps

module op_decoder (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic [exu_pkg::xlen-1:0]      instr,
    input  logic [exu_pkg::xlen-1:0]      pc,
    input  logic [exu_pkg::xlen-1:0]      rs1_d,
    input  logic [exu_pkg::xlen-1:0]      rs2_d,
    input  logic                          credit_return,
    output logic                          push,
    output exu_pkg::issue_pkt_t           push_pkt
);

    logic [exu_pkg::credit_w-1:0] credits;
    logic                         accept;
    logic [6:0]                   opcode;
    logic [2:0]                   funct3;
    logic [6:0]                   funct7;
    logic [exu_pkg::xlen-1:0]     imm_i, imm_s, imm_u, imm_j;
    exu_pkg::issue_pkt_t          dec_pkt;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // immediates, all sign extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign in_ready = (credits != '0);   // one free queue slot reserved per credit
    assign accept   = in_valid && in_ready;

    always_comb begin
        dec_pkt         = '0;            // imm_zero / add / pc+4 / no store
        dec_pkt.pc      = pc;
        dec_pkt.rs1_d   = rs1_d;
        dec_pkt.rs2_d   = rs2_d;
        dec_pkt.illegal = 1'b1;          // cleared by any recognised encoding
        case (opcode)
            exu_pkg::op_reg: begin
                dec_pkt.src_sel = exu_pkg::src_rs1_rs2;
                dec_pkt.illegal = 1'b0;
                case (funct3)
                    3'b000: dec_pkt.alu_op = funct7[5] ? exu_pkg::alu_sub : exu_pkg::alu_add;
                    3'b111: dec_pkt.alu_op = exu_pkg::alu_and;
                    3'b110: dec_pkt.alu_op = exu_pkg::alu_or;
                    3'b100: dec_pkt.alu_op = exu_pkg::alu_xor;
                    3'b010: dec_pkt.alu_op = exu_pkg::alu_slt;
                    default: dec_pkt.illegal = 1'b1;   // shifts, sltu
                endcase
                // only sub may set funct7, and only bit 5
                if (funct7 != 7'b0 && !(funct7 == 7'b0100000 && funct3 == 3'b000))
                    dec_pkt.illegal = 1'b1;
            end
            exu_pkg::op_imm: begin
                dec_pkt.src_sel = exu_pkg::src_rs1_imm;
                dec_pkt.imm     = imm_i;
                dec_pkt.illegal = (funct3 != 3'b000);  // addi only
            end
            exu_pkg::op_lui: begin
                dec_pkt.alu_op  = exu_pkg::alu_pass_b;
                dec_pkt.imm     = imm_u;
                dec_pkt.illegal = 1'b0;
            end
            exu_pkg::op_auipc: begin
                dec_pkt.src_sel = exu_pkg::src_pc_imm;
                dec_pkt.imm     = imm_u;
                dec_pkt.illegal = 1'b0;
            end
            exu_pkg::op_jal: begin
                dec_pkt.npc_sel = exu_pkg::npc_pc_imm;
                dec_pkt.imm     = imm_j;
                dec_pkt.is_link = 1'b1;
                dec_pkt.illegal = 1'b0;
            end
            exu_pkg::op_jalr: begin
                dec_pkt.npc_sel = exu_pkg::npc_rs1_imm;
                dec_pkt.imm     = imm_i;
                dec_pkt.is_link = 1'b1;
                dec_pkt.illegal = (funct3 != 3'b000);
            end
            exu_pkg::op_load: begin
                dec_pkt.src_sel = exu_pkg::src_rs1_imm;   // address = rs1 + imm
                dec_pkt.imm     = imm_i;
                dec_pkt.is_load = 1'b1;
                dec_pkt.illegal = (funct3 != 3'b010);     // lw only
            end
            exu_pkg::op_store: begin
                dec_pkt.src_sel = exu_pkg::src_rs1_imm;
                dec_pkt.imm     = imm_s;
                dec_pkt.illegal = 1'b0;
                case (funct3)
                    3'b000:  dec_pkt.mem_size = exu_pkg::mem_byte;
                    3'b001:  dec_pkt.mem_size = exu_pkg::mem_half;
                    3'b010:  dec_pkt.mem_size = exu_pkg::mem_word;
                    default: dec_pkt.illegal  = 1'b1;
                endcase
            end
            default: begin
                if (instr == exu_pkg::ebreak_instr) begin
                    dec_pkt.is_ebreak = 1'b1;
                    dec_pkt.illegal   = 1'b0;
                end
            end
        endcase
    end

    // credit is spent at acceptance so the push one edge later always has a slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= exu_pkg::credit_w'(exu_pkg::queue_depth);
            push    <= 1'b0;
        end else begin
            push <= accept;
            case ({accept, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;       // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            push_pkt <= dec_pkt;   // payload, qualified by push
    end

endmodule

/* verilog/issue_queue.sv */
`timescale 1ns/100ps

module issue_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  exu_pkg::issue_pkt_t push_pkt,
    input  logic                pop,
    output logic                q_valid,
    output exu_pkg::issue_pkt_t q_pkt,
    output logic                credit_return
);

    exu_pkg::issue_pkt_t          entries [exu_pkg::queue_depth];
    logic [exu_pkg::qptr_w-1:0]   wr_ptr;
    logic [exu_pkg::qptr_w-1:0]   rd_ptr;
    logic [exu_pkg::credit_w-1:0] count;   // occupancy, 0..queue_depth

    assign q_valid = (count != '0);
    assign q_pkt   = entries[rd_ptr];   // head entry

    // pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;            // one credit back per pop
            if (push)
                wr_ptr <= wr_ptr + 1'b1;     // depth is a power of two, wraps on its own
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage, no full check since the decoder never pushes without a credit
    always_ff @(posedge clk) begin
        if (push)
            entries[wr_ptr] <= push_pkt;
    end

endmodule

/* execute/exec_unit.sv */
`timescale 1ns/100ps

module exec_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          q_valid,
    input  exu_pkg::issue_pkt_t           q_pkt,
    output logic                          pop,
    output logic                          mem_we,
    output logic [exu_pkg::mem_aw-1:0]    mem_addr,
    output logic [exu_pkg::xlen-1:0]      mem_wdata,
    output logic [exu_pkg::xlen/8-1:0]    mem_wmask,
    input  logic [exu_pkg::xlen-1:0]      mem_rdata,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [exu_pkg::xlen-1:0]      rd_d,
    output logic [exu_pkg::xlen-1:0]      dnpc,
    output logic                          halt,
    output logic                          illegal
);

    logic [exu_pkg::xlen-1:0]   op_a, op_b, alu_res;
    logic [exu_pkg::xlen-1:0]   npc_a, npc_b, next_pc;
    logic [exu_pkg::xlen-1:0]   link_pc;
    logic [exu_pkg::xlen-1:0]   rd_sel;
    logic [exu_pkg::xlen/8-1:0] base_mask;
    logic [1:0]                 byte_off;

    // take the head whenever the result slot is free or draining this cycle
    assign pop = q_valid && (!out_valid || out_ready);

    // alu operand pair
    always_comb begin
        case (q_pkt.src_sel)
            exu_pkg::src_imm_zero: {op_a, op_b} = {{exu_pkg::xlen{1'b0}}, q_pkt.imm};
            exu_pkg::src_pc_imm:   {op_a, op_b} = {q_pkt.pc, q_pkt.imm};
            exu_pkg::src_rs1_rs2:  {op_a, op_b} = {q_pkt.rs1_d, q_pkt.rs2_d};
            default:               {op_a, op_b} = {q_pkt.rs1_d, q_pkt.imm};
        endcase
    end

    alu u_alu (
        .a   (op_a),
        .b   (op_b),
        .op  (q_pkt.alu_op),
        .res (alu_res)
    );

    // next pc, own adder so it never waits on the alu
    always_comb begin
        case (q_pkt.npc_sel)
            exu_pkg::npc_pc_imm:  {npc_a, npc_b} = {q_pkt.pc, q_pkt.imm};
            exu_pkg::npc_rs1_imm: {npc_a, npc_b} = {q_pkt.rs1_d, q_pkt.imm};
            default:              {npc_a, npc_b} = {q_pkt.pc, exu_pkg::xlen'(4)};
        endcase
    end
    assign next_pc = npc_a + npc_b;
    assign link_pc = q_pkt.pc + exu_pkg::xlen'(4);

    // store path, sub-word data and mask move up to the addressed byte lane
    always_comb begin
        case (q_pkt.mem_size)
            exu_pkg::mem_byte: base_mask = 4'h1;
            exu_pkg::mem_half: base_mask = 4'h3;
            exu_pkg::mem_word: base_mask = 4'hf;
            default:           base_mask = 4'h0;
        endcase
    end
    assign byte_off  = alu_res[1:0];
    assign mem_addr  = alu_res[exu_pkg::mem_aw+1:2];   // word address
    assign mem_wdata = q_pkt.rs2_d << {byte_off, 3'b000};
    assign mem_wmask = base_mask << byte_off;
    assign mem_we    = pop && (q_pkt.mem_size != exu_pkg::mem_none);  // lands on the pop edge

    // rd source: load data, link address, halt code, else alu (stores give the address)
    always_comb begin
        if (q_pkt.is_load)
            rd_sel = mem_rdata;
        else if (q_pkt.is_link)
            rd_sel = link_pc;
        else if (q_pkt.is_ebreak)
            rd_sel = q_pkt.rs1_d;
        else
            rd_sel = alu_res;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            halt      <= 1'b0;
            illegal   <= 1'b0;
        end else if (pop) begin
            out_valid <= 1'b1;
            halt      <= q_pkt.is_ebreak;
            illegal   <= q_pkt.illegal;
        end else if (out_ready) begin
            out_valid <= 1'b0;   // drained with nothing behind it
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin           // holds while stalled
            rd_d <= rd_sel;
            dnpc <= next_pc;
        end
    end

endmodule

/* verilog/data_mem.sv */
`timescale 1ns/100ps

module data_mem (
    input  logic                         clk,
    input  logic                         we,
    input  logic [exu_pkg::mem_aw-1:0]   addr,
    input  logic [exu_pkg::xlen-1:0]     wdata,
    input  logic [exu_pkg::xlen/8-1:0]   wmask,
    output logic [exu_pkg::xlen-1:0]     rdata
);

    logic [exu_pkg::xlen-1:0] mem [exu_pkg::mem_words];

    // simulation starts from an all-zero memory
    initial begin
        for (int i = 0; i < exu_pkg::mem_words; i++)
            mem[i] = '0;
    end

    assign rdata = mem[addr];   // combinational word read

    // byte lanes written only where the mask is set
    always_ff @(posedge clk) begin
        if (we) begin
            for (int lane = 0; lane < exu_pkg::xlen/8; lane++) begin
                if (wmask[lane])
                    mem[addr][lane*8 +: 8] <= wdata[lane*8 +: 8];
            end
        end
    end

endmodule

/* verilog/exu_top.sv */
`timescale 1ns/100ps

module exu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [exu_pkg::xlen-1:0] instr,
    input  logic [exu_pkg::xlen-1:0] pc,
    input  logic [exu_pkg::xlen-1:0] rs1_d,
    input  logic [exu_pkg::xlen-1:0] rs2_d,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [exu_pkg::xlen-1:0] rd_d,
    output logic [exu_pkg::xlen-1:0] dnpc,
    output logic                     halt,
    output logic                     illegal
);

    logic                         push, pop, q_valid, credit_return;
    exu_pkg::issue_pkt_t          push_pkt, q_pkt;
    logic                         mem_we;
    logic [exu_pkg::mem_aw-1:0]   mem_addr;
    logic [exu_pkg::xlen-1:0]     mem_wdata, mem_rdata;
    logic [exu_pkg::xlen/8-1:0]   mem_wmask;

    op_decoder u_op_decoder (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .instr         (instr),
        .pc            (pc),
        .rs1_d         (rs1_d),
        .rs2_d         (rs2_d),
        .credit_return (credit_return),
        .push          (push),
        .push_pkt      (push_pkt)
    );

    issue_queue u_issue_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (push),
        .push_pkt      (push_pkt),
        .pop           (pop),
        .q_valid       (q_valid),
        .q_pkt         (q_pkt),
        .credit_return (credit_return)
    );

    exec_unit u_exec_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .q_valid   (q_valid),
        .q_pkt     (q_pkt),
        .pop       (pop),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wmask (mem_wmask),
        .mem_rdata (mem_rdata),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .rd_d      (rd_d),
        .dnpc      (dnpc),
        .halt      (halt),
        .illegal   (illegal)
    );

    data_mem u_data_mem (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .wmask (mem_wmask),
        .rdata (mem_rdata)
    );

endmodule

/* sim/exu_checker.sv */
`timescale 1ns/100ps

module exu_checker (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          push,
    input logic                          pop,
    input logic                          credit_return,
    input logic [exu_pkg::credit_w-1:0]  occupancy,   // issue queue fill level
    input logic [exu_pkg::credit_w-1:0]  credits,     // decoder credit counter
    input logic                          out_valid,
    input logic                          out_ready,
    input logic [exu_pkg::xlen-1:0]      rd_d,
    input logic [exu_pkg::xlen-1:0]      dnpc,
    input logic                          halt,
    input logic                          illegal
);

    // queue never holds more than its depth
    a_occupancy: assert property (@(posedge clk) disable iff (!rst_n)
        occupancy <= exu_pkg::credit_w'(exu_pkg::queue_depth))
        else $error("issue queue occupancy above its depth");

    // a push is the accept of the cycle before, which needed a credit
    a_push_credit: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> $past(credits) != '0)
        else $error("push issued without a credit");

    a_pop_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> occupancy != '0)   // queue's own fill count
        else $error("pop from an empty issue queue");

    // each credit sits in the decoder, on a push, in the queue or on its way back
    a_credit_conserve: assert property (@(posedge clk) disable iff (!rst_n)
        int'(credits) + int'(occupancy) + int'(push) + int'(credit_return)
            == exu_pkg::queue_depth)
        else $error("credits lost or created between decoder and issue queue");

    // result holds while the consumer stalls
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(rd_d) && $stable(dnpc)
            && $stable(halt) && $stable(illegal))
        else $error("result changed while stalled");

endmodule

/* sim/tb_exu_top.sv */
`timescale 1ns/100ps

module tb_exu_top;

    localparam int wait_limit = 200;   // cycles any one wait may take

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] rd;     // expected rd_d
        logic [31:0] npc;    // expected dnpc
        logic        halt;
        logic        ill;
    } case_t;

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid, in_ready;
    logic                     out_valid, out_ready;
    logic                     halt, illegal;
    logic [exu_pkg::xlen-1:0] instr, pc, rs1_d, rs2_d;
    logic [exu_pkg::xlen-1:0] rd_d, dnpc;

    case_t       cases[$];
    case_t       exp_q[$];    // accepted, not yet seen at the output
    int          id_q[$];
    int          n_checked;
    int          n_failed;
    int          n_errors;    // failures that are not a case mismatch
    bit          aborted;

    exu_top u_exu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .instr     (instr),
        .pc        (pc),
        .rs1_d     (rs1_d),
        .rs2_d     (rs2_d),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .rd_d      (rd_d),
        .dnpc      (dnpc),
        .halt      (halt),
        .illegal   (illegal)
    );

    bind exu_top exu_checker u_exu_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (push),
        .pop           (pop),
        .credit_return (credit_return),
        .occupancy     (u_issue_queue.count),
        .credits       (u_op_decoder.credits),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .rd_d          (rd_d),
        .dnpc          (dnpc),
        .halt          (halt),
        .illegal       (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    // random consumer stalls, about one cycle in three
    initial begin
        out_ready <= 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n)
                out_ready <= ($urandom_range(99) < 65);
        end
    end

    task automatic load_cases();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f_instr, f_pc, f_rs1, f_rs2, f_rd, f_npc;
        logic        f_halt, f_ill;
        fd = $fopen("sim/exu_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/exu_cases.txt");
            n_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == 8'h23)   // blank or # comment
                    continue;
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h", f_instr, f_pc, f_rs1,
                              f_rs2, f_rd, f_npc, f_halt, f_ill);
                if (cnt == 8) begin
                    cases.push_back({f_instr, f_pc, f_rs1, f_rs2, f_rd, f_npc, f_halt, f_ill});
                end else begin
                    $display("malformed line in cases file: %s", line);
                    n_errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    // producer side, one case per accepted transfer
    task automatic drive_cases();
        int  waited;
        bit  accepted;
        for (int i = 0; i < cases.size() && !aborted; i++) begin
            if ($urandom_range(3) == 0) begin   // occasional idle cycle
                in_valid <= 1'b0;
                @(posedge clk);
            end
            in_valid <= 1'b1;
            instr    <= cases[i].instr;
            pc       <= cases[i].pc;
            rs1_d    <= cases[i].rs1;
            rs2_d    <= cases[i].rs2;
            waited   = 0;
            accepted = 1'b0;
            while (!accepted && waited < wait_limit) begin
                @(negedge clk);
                accepted = in_ready;   // transfer on the coming edge
                @(posedge clk);
                waited++;
            end
            if (accepted) begin
                exp_q.push_back(cases[i]);
                id_q.push_back(i);
            end else begin
                $display("timeout: decoder never accepted case %0d", i);
                aborted = 1'b1;
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic check_result(input case_t want, input int id);
        bit ok;
        ok = 1'b1;
        assert (illegal === want.ill) else begin
            $display("ERROR case %0d: illegal got %h expected %h", id, illegal, want.ill);
            ok = 1'b0;
        end
        assert (halt === want.halt) else begin
            $display("ERROR case %0d: halt got %h expected %h", id, halt, want.halt);
            ok = 1'b0;
        end
        if (!want.ill) begin   // rd_d and dnpc undefined for illegal encodings
            assert (rd_d === want.rd) else begin
                $display("ERROR case %0d: rd_d got %08h expected %08h", id, rd_d, want.rd);
                ok = 1'b0;
            end
            assert (dnpc === want.npc) else begin
                $display("ERROR case %0d: dnpc got %08h expected %08h", id, dnpc, want.npc);
                ok = 1'b0;
            end
        end
        if (!ok)
            n_failed++;
        n_checked++;
        $display("case %0d  instr %08h  pc %08h  rd_d %08h  dnpc %08h  %s",
                 id, want.instr, want.pc, rd_d, dnpc, ok ? "ok" : "mismatch");
    endtask

    // consumer side, results must come back in issue order
    task automatic collect_results();
        int    waited;
        bit    seen;
        case_t want;
        int    id;
        while (n_checked < cases.size() && !aborted) begin
            waited = 0;
            seen   = 1'b0;
            while (!seen && waited < wait_limit) begin
                @(negedge clk);
                seen = out_valid && out_ready;   // taken on the next rising edge
                waited++;
            end
            if (!seen) begin
                $display("timeout: no result for case %0d after %0d cycles",
                         n_checked, wait_limit);
                aborted = 1'b1;
            end else if (exp_q.size() == 0) begin
                $display("result appeared with no case outstanding");
                n_errors++;
                aborted = 1'b1;
            end else begin
                want = exp_q.pop_front();
                id   = id_q.pop_front();
                check_result(want, id);
            end
        end
    endtask

    // a duplicate would show up as a late extra handshake
    task automatic watch_for_extras();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            assert (!(out_valid && out_ready)) else begin
                $display("extra result after the last case, rd_d %08h", rd_d);
                n_errors++;
            end
        end
    endtask

    initial begin
        rst_n     <= 1'b0;
        in_valid  <= 1'b0;
        instr     <= '0;
        pc        <= '0;
        rs1_d     <= '0;
        rs2_d     <= '0;
        n_checked = 0;
        n_failed  = 0;
        n_errors  = 0;
        aborted   = 1'b0;
        void'($urandom(32'h34bb));   // fixes every later draw
        load_cases();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        if (cases.size() > 0 && n_errors == 0) begin
            fork
                drive_cases();
                collect_results();
            join
            if (!aborted)
                watch_for_extras();
        end
        $display("cases %0d, checked %0d, failed %0d, other errors %0d",
                 cases.size(), n_checked, n_failed, n_errors);
        if (!aborted && n_errors == 0 && n_failed == 0 && cases.size() > 0
            && n_checked == cases.size())
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* sim/exu_cases.txt */
# instr    pc       rs1_d    rs2_d    rd_d     dnpc     halt illegal   (hex)
# rd_d and dnpc are not compared on lines where illegal is 1
007302b3 00001000 00001234 00000fff 00002233 00001004 0 0
407302b3 00001004 00000010 00000020 fffffff0 00001008 0 0
007372b3 00001008 f0f0f0f0 ff00ff00 f000f000 0000100c 0 0
007362b3 0000100c f0f0f0f0 0f000f00 fff0fff0 00001010 0 0
007342b3 00001010 aaaa5555 ffff0000 55555555 00001014 0 0
007322b3 00001014 ffffffff 00000001 00000001 00001018 0 0
007322b3 00001018 00000005 fffffff0 00000000 0000101c 0 0
ffb30293 0000101c 00000003 00000000 fffffffe 00001020 0 0
123452b7 00001020 deadbeef cafef00d 12345000 00001024 0 0
00001297 00001024 00000000 00000000 00002024 00001028 0 0
010000ef 00001028 00000000 00000000 0000102c 00001038 0 0
ff9ff0ef 00001038 00000000 00000000 0000103c 00001030 0 0
004300e7 00001030 00002000 00000000 00001034 00002004 0 0
00732423 00002004 00000100 11223344 00000108 00002008 0 0
00832283 00002008 00000100 00000000 11223344 0000200c 0 0
00731423 0000200c 00000102 aaaabeef 0000010a 00002010 0 0
00730423 00002010 00000101 123456a5 00000109 00002014 0 0
00832283 00002014 00000100 00000000 beefa544 00002018 0 0
007312b3 00002018 00000001 00000002 00000000 00000000 0 1
00730463 0000201c 00000001 00000002 00000000 00000000 0 1
00100073 00002020 0000002a 00000000 0000002a 00002024 1 0

/* vlog.f */
common/exu_pkg.sv
execute/alu.sv
decode/op_decoder.sv
verilog/issue_queue.sv
execute/exec_unit.sv
verilog/data_mem.sv
verilog/exu_top.sv
sim/exu_checker.sv
sim/tb_exu_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exu_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --assert $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
